/* tart_top.f */
+incdir+logic
+incdir+test
logic/tart_pkg.sv
logic/spi_wb_master.sv
logic/bus_decoder.sv
logic/tart_control.sv
logic/tart_acquire.sv
logic/capture_buffer.sv
logic/tart_top.sv
test/tb_tart_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the tart_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_tart_top -f tart_top.f -o tb_tart_top

./obj_dir/tb_tart_top | tee sim.log

if grep -qx "TESTS PASSED" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

/* test/spi_host_tasks.svh */
`ifndef SPI_HOST_TASKS_SVH
`define SPI_HOST_TASKS_SVH

// one byte, msb first, sck idles low
task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
   for (int i = 7; i >= 0; i--) begin
      mosi_i = tx[i];                     // set up while sck low
      repeat (SCK_HALF) @(negedge fpga_clk);
      rx[i] = miso_o;                     // sampled as sck rises
      sck_i = 1'b1;
      repeat (SCK_HALF) @(negedge fpga_clk);
      sck_i = 1'b0;                       // dut shifts next bit out
   end
endtask

// command byte, then n bytes of wdat; replies land in frame_rx
task automatic spi_frame(input logic [7:0] cmd, input logic [7:0] wdat, input int n);
   logic [7:0] rx;
   @(negedge fpga_clk);
   ssel_i = 1'b0;
   repeat (SCK_HALF) @(negedge fpga_clk);
   spi_byte(cmd, frame_stat);             // status comes back with the command
   for (int k = 0; k < n; k++) begin
      spi_byte(wdat, rx);
      frame_rx[k] = rx;
   end
   repeat (SCK_HALF) @(negedge fpga_clk);   // let the last transfer finish
   ssel_i = 1'b1;
   repeat (GAP_CLKS) @(negedge fpga_clk);
endtask

task automatic read_status(input logic [6:0] adr, output logic [7:0] st);
   spi_frame({1'b0, adr}, 8'h00, 0);
   st = frame_stat;
endtask

// repeat status reads until the state field matches
task automatic poll_status(input logic [6:0] adr, input logic [2:0] state,
                           output logic [7:0] st, output bit hit);
   hit = 1'b0;
   for (int i = 0; i < POLL_LIMIT && !hit; i++) begin
      read_status(adr, st);
      hit = st[2:0] == state;
   end
endtask

`endif

/* test/tb_tart_top.sv */
`timescale 1ns/1ps
`include "tart_cfg.svh"
`default_nettype none

module tb_tart_top;

   import tart_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int SCK_HALF   = 4;                      // sck at fpga_clk/8
   localparam int GAP_CLKS   = 8;                      // ssel high between frames
   localparam int BYTE_CLKS  = 16 * SCK_HALF;
   localparam int NBYTES     = 3 * `TART_BUF_DEPTH;    // one whole capture
   localparam int FRAME_CLKS = (NBYTES + 1) * BYTE_CLKS + 2 * SCK_HALF + GAP_CLKS + 1;
   localparam int STAT_CLKS  = BYTE_CLKS + 2 * SCK_HALF + GAP_CLKS + 1;
   localparam int POLL_LIMIT = 10;

   localparam logic [2:0] OP_WR     = 3'd0;
   localparam logic [2:0] OP_RD     = 3'd1;
   localparam logic [2:0] OP_STAT   = 3'd2;
   localparam logic [2:0] OP_POLL   = 3'd3;
   localparam logic [2:0] OP_STREAM = 3'd4;   // dat[0] set for debug counter data
   localparam logic [2:0] OP_ANT    = 3'd5;   // new antenna pattern

   localparam logic [6:0] ADR_SAMPLES = {`TART_AQ_UNIT, 3'd0};
   localparam logic [6:0] ADR_DELAY   = {`TART_AQ_UNIT, 3'd5};
   localparam logic [6:0] ADR_DEBUG   = {`TART_AQ_UNIT, 3'd6};
   localparam logic [6:0] ADR_ENABLE  = {`TART_AQ_UNIT, 3'd7};
   localparam logic [6:0] ADR_CTRL    = {`TART_CTRL_UNIT, 2'd0};
   localparam logic [6:0] ADR_NONE    = 7'h20;   // neither unit

   typedef struct packed {
      logic [2:0] op;
      logic [6:0] adr;
      logic [7:0] dat;
      logic [7:0] want;   // expected byte or status
   } row_t;

   logic       fpga_clk;
   logic       rst_i;
   logic       sck_i;
   logic       ssel_i;
   logic       mosi_i;
   wire        miso_o;
   ant_t       ant_i;
   wire        led_o;
   row_t       rows [$];
   logic [7:0] frame_rx [NBYTES];
   logic [7:0] frame_stat;
   ant_t       ant_pattern;
   integer     seed;
   int         checks;
   int         value_errors;
   int         other_errors;
   int         n_polls;
   bit         table_ready;

   tart_top dut (
      .fpga_clk (fpga_clk),
      .rst_i    (rst_i),
      .sck_i    (sck_i),
      .ssel_i   (ssel_i),
      .mosi_i   (mosi_i),
      .miso_o   (miso_o),
      .ant_i    (ant_i),
      .led_o    (led_o)
   );

   always #(CLK_PERIOD / 2) fpga_clk = ~fpga_clk;

   `include "spi_host_tasks.svh"

   //--------------------------------------------------
   // expected values
   function automatic logic [7:0] status_word(input logic drained, input logic en,
                                              input logic dbg, input logic [2:0] state);
      return {1'b1, 1'b0, drained, en, dbg, state};   // bit 6 reads 0
   endfunction

   task automatic add_row(input logic [2:0] op, input logic [6:0] adr,
                          input logic [7:0] dat, input logic [7:0] want);
      rows.push_back('{op: op, adr: adr, dat: dat, want: want});
      if (op == OP_POLL)
         n_polls++;
   endtask

   task automatic build_table();
      add_row(OP_STAT, ADR_CTRL, 8'h00, status_word(1'b0, 1'b0, 1'b0, 3'd0));
      add_row(OP_WR, ADR_DELAY, 8'hff, 8'h00);        // masks to 3 bits
      add_row(OP_WR, ADR_DEBUG, 8'hff, 8'h00);
      add_row(OP_WR, ADR_ENABLE, 8'hff, 8'h00);       // delay 7 never strobes
      add_row(OP_RD, ADR_DELAY, 8'h00, 8'h07);
      add_row(OP_RD, ADR_DEBUG, 8'h00, 8'h01);
      add_row(OP_RD, ADR_ENABLE, 8'h00, 8'h01);
      add_row(OP_RD, ADR_NONE, 8'h00, 8'h00);
      add_row(OP_WR, ADR_ENABLE, 8'h00, 8'h00);
      add_row(OP_STAT, ADR_CTRL, 8'h00, status_word(1'b0, 1'b0, 1'b1, 3'd0));
      // debug counter capture
      add_row(OP_WR, ADR_DELAY, 8'h02, 8'h00);
      add_row(OP_WR, ADR_DEBUG, 8'h01, 8'h00);
      add_row(OP_WR, ADR_ENABLE, 8'h01, 8'h00);
      add_row(OP_POLL, ADR_CTRL, 8'h00, status_word(1'b0, 1'b1, 1'b1, 3'd2));
      add_row(OP_STREAM, ADR_SAMPLES, 8'h01, 8'h00);
      add_row(OP_STAT, ADR_CTRL, 8'h00, status_word(1'b1, 1'b1, 1'b1, 3'd3));
      // antenna captures at two delays
      add_row(OP_WR, ADR_ENABLE, 8'h00, 8'h00);
      add_row(OP_WR, ADR_DEBUG, 8'h00, 8'h00);
      add_row(OP_WR, ADR_DELAY, 8'h04, 8'h00);
      add_row(OP_ANT, ADR_NONE, 8'h00, 8'h00);
      add_row(OP_WR, ADR_ENABLE, 8'h01, 8'h00);
      add_row(OP_POLL, ADR_CTRL, 8'h00, status_word(1'b0, 1'b1, 1'b0, 3'd2));
      add_row(OP_STREAM, ADR_SAMPLES, 8'h00, 8'h00);
      add_row(OP_STAT, ADR_CTRL, 8'h00, status_word(1'b1, 1'b1, 1'b0, 3'd3));
      add_row(OP_WR, ADR_ENABLE, 8'h00, 8'h00);
      add_row(OP_WR, ADR_DELAY, 8'h01, 8'h00);
      add_row(OP_ANT, ADR_NONE, 8'h00, 8'h00);
      add_row(OP_WR, ADR_ENABLE, 8'h01, 8'h00);
      add_row(OP_POLL, ADR_CTRL, 8'h00, status_word(1'b0, 1'b1, 1'b0, 3'd2));
      add_row(OP_STREAM, ADR_SAMPLES, 8'h00, 8'h00);
      add_row(OP_STAT, ADR_CTRL, 8'h00, status_word(1'b1, 1'b1, 1'b0, 3'd3));
      // soft reset through control register 0
      add_row(OP_WR, ADR_DEBUG, 8'h01, 8'h00);        // all three set beforehand
      add_row(OP_WR, ADR_CTRL, 8'h00, 8'h00);
      add_row(OP_RD, ADR_ENABLE, 8'h00, 8'h00);
      add_row(OP_RD, ADR_DEBUG, 8'h00, 8'h00);
      add_row(OP_RD, ADR_DELAY, 8'h00, 8'h00);
      add_row(OP_STAT, ADR_CTRL, 8'h00, status_word(1'b0, 1'b0, 1'b0, 3'd0));
   endtask

   //--------------------------------------------------
   // checks
   task automatic check_byte(input logic [7:0] got, input logic [7:0] want, input string what);
      checks++;
      assert (got === want) else begin
         value_errors++;
         $display("Error at %0t ns: %s is 0x%02h, expected 0x%02h", $time, what, got, want);
      end
   endtask

   task automatic check_led(input logic [7:0] st);
      logic want;
      want = st[2:0] >= 3'd2;   // data ready, no soft reset running
      checks++;
      assert (led_o === want) else begin
         value_errors++;
         $display("Error at %0t ns: led_o is %b, expected %b", $time, led_o, want);
      end
   endtask

   task automatic stream_samples(input logic dbg);
      logic [23:0] want;
      spi_frame({1'b0, ADR_SAMPLES}, 8'h00, NBYTES);
      for (int k = 0; k < NBYTES; k++) begin
         want = dbg ? 24'(k / 3) : ant_pattern;   // low byte first
         check_byte(frame_rx[k], want[8 * (k % 3) +: 8],
                    $sformatf("sample %0d byte %0d", k / 3, k % 3));
      end
   endtask

   task automatic apply_row(input row_t row);
      logic [7:0]  st;
      logic [31:0] rnd;
      bit          hit;
      case (row.op)
         OP_WR: spi_frame({1'b1, row.adr}, row.dat, 1);
         OP_RD: begin
            spi_frame({1'b0, row.adr}, 8'h00, 1);
            check_byte(frame_rx[0], row.want, $sformatf("register 0x%02h", row.adr));
         end
         OP_STAT: begin
            read_status(row.adr, st);
            check_byte(st, row.want, "status");
            check_led(row.want);
         end
         OP_POLL: begin
            poll_status(row.adr, row.want[2:0], st, hit);
            assert (hit) else begin
               other_errors++;
               $display("capture never reached state %0d in %0d status reads",
                        row.want[2:0], POLL_LIMIT);
            end
            check_byte(st, row.want, "status after poll");
            check_led(row.want);
         end
         OP_STREAM: stream_samples(row.dat[0]);
         default: begin   // held for the whole capture
            rnd         = $random(seed);
            ant_pattern = rnd[23:0];
            ant_i       = ant_pattern;
         end
      endcase
   endtask

   //--------------------------------------------------
   initial begin
      fpga_clk = 1'b0;
      rst_i    = 1'b1;
      sck_i    = 1'b0;
      ssel_i   = 1'b1;   // deselected
      mosi_i   = 1'b0;
      ant_i    = '0;
      seed     = 32'ha720_827d;
      build_table();
      table_ready = 1'b1;
      repeat (3) @(negedge fpga_clk);
      rst_i = 1'b0;
      repeat (4) @(negedge fpga_clk);
      foreach (rows[r])
         apply_row(rows[r]);
      $display("checks %0d, value errors %0d, other failures %0d",
               checks, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   // watchdog sized for a full stream frame per row plus polling
   initial begin : watchdog
      longint limit_ns;
      wait (table_ready);
      limit_ns = longint'(8 + rows.size() * FRAME_CLKS + n_polls * POLL_LIMIT * STAT_CLKS)
                 * CLK_PERIOD;
      #(limit_ns);
      $display("watchdog expired after %0d ns, the test sequence did not finish", limit_ns);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* logic/tart_top.sv */
`timescale 1ns/1ps
`include "tart_cfg.svh"
`default_nettype none

module tart_top (
   input  wire                  fpga_clk,
   input  wire                  rst_i,
   input  wire                  sck_i,
   input  wire                  ssel_i,
   input  wire                  mosi_i,
   output wire                  miso_o,
   input  wire tart_pkg::ant_t  ant_i,
   output wire                  led_o
);

   import tart_pkg::*;

   bus_req_t   b_req;
   bus_rsp_t   b_rsp, aq_rsp, ctrl_rsp;
   logic       aq_stb, ctrl_stb;
   logic       soft_rst;
   logic       debug_mode, aq_enable, drained;
   logic [2:0] sample_delay;
   logic [$clog2(`TART_BUF_DEPTH)-1:0] rd_index;
   ant_t       sample;
   cap_state_t cap_state;
   logic [7:0] status;

   // bit 6 was the overflow flag, now always 0
   assign status = {1'b1, 1'b0, drained, aq_enable, debug_mode, cap_state};
   assign led_o  = (cap_state >= CAP_READY) | soft_rst;   // data ready or resetting

   //--------------------------------------------------
   // spi slave, bus master side
   spi_wb_master spi_slave0 (
      .fpga_clk (fpga_clk),
      .rst_i    (rst_i),
      .sck_i    (sck_i),
      .ssel_i   (ssel_i),
      .mosi_i   (mosi_i),
      .miso_o   (miso_o),
      .status_i (status),
      .bus_o    (b_req),
      .bus_i    (b_rsp)
   );

   bus_decoder bus_dec0 (
      .fpga_clk   (fpga_clk),
      .rst_i      (rst_i),
      .bus_i      (b_req),
      .aq_stb_o   (aq_stb),
      .ctrl_stb_o (ctrl_stb),
      .aq_rsp_i   (aq_rsp),
      .ctrl_rsp_i (ctrl_rsp),
      .bus_o      (b_rsp)
   );

   //--------------------------------------------------
   // reset handler and acquisition
   tart_control wb_reset0 (
      .fpga_clk   (fpga_clk),
      .rst_i      (rst_i),
      .stb_i      (ctrl_stb),
      .bus_i      (b_req),
      .rsp_o      (ctrl_rsp),
      .status_i   (status),
      .soft_rst_o (soft_rst)
   );

   tart_acquire tart_acquire0 (
      .fpga_clk       (fpga_clk),
      .soft_rst_i     (soft_rst),
      .stb_i          (aq_stb),
      .bus_i          (b_req),
      .rsp_o          (aq_rsp),
      .sample_delay_o (sample_delay),
      .debug_mode_o   (debug_mode),
      .aq_enable_o    (aq_enable),
      .rd_index_o     (rd_index),
      .sample_i       (sample),
      .state_i        (cap_state),
      .drained_o      (drained)
   );

   capture_buffer aq_bb0 (
      .fpga_clk       (fpga_clk),
      .soft_rst_i     (soft_rst),
      .ant_i          (ant_i),
      .sample_delay_i (sample_delay),
      .debug_mode_i   (debug_mode),
      .aq_enable_i    (aq_enable),
      .rd_index_i     (rd_index),
      .sample_o       (sample),
      .drained_i      (drained),
      .state_o        (cap_state)
   );

endmodule

`default_nettype wire

/* logic/capture_buffer.sv */
`timescale 1ns/1ps
`include "tart_cfg.svh"
`default_nettype none

module capture_buffer (
   input  wire                                fpga_clk,
   input  wire                                soft_rst_i,
   input  wire tart_pkg::ant_t                ant_i,
   input  wire [2:0]                          sample_delay_i,
   input  wire                                debug_mode_i,
   input  wire                                aq_enable_i,
   input  wire [$clog2(`TART_BUF_DEPTH)-1:0]  rd_index_i,
   output tart_pkg::ant_t                     sample_o,
   input  wire                                drained_i,
   output tart_pkg::cap_state_t               state_o
);

   import tart_pkg::*;

   localparam int IDX_W = $clog2(`TART_BUF_DEPTH);

   ant_t             mem [`TART_BUF_DEPTH];
   ant_t             ant_q;      // io register
   ant_t             dbg_cnt;    // fake antenna data
   logic [2:0]       div_cnt;    // sample phase, same width as delay
   logic [IDX_W-1:0] wr_ptr;
   logic             en_q;
   logic             strobe;

   assign strobe = div_cnt == sample_delay_i;

   always_ff @(posedge fpga_clk) begin
      ant_q <= ant_i;
      if (soft_rst_i || div_cnt == 3'(`TART_SAMPLE_DIV - 1))
         div_cnt <= '0;
      else
         div_cnt <= div_cnt + 3'd1;
   end

   //--------------------------------------------------
   // capture FSM
   always_ff @(posedge fpga_clk) begin
      if (soft_rst_i) begin
         state_o <= CAP_IDLE;
         en_q    <= 1'b0;
         wr_ptr  <= '0;
         dbg_cnt <= '0;
      end else begin
         en_q <= aq_enable_i;
         if (!aq_enable_i) begin
            state_o <= CAP_IDLE;
         end else begin
            case (state_o)
               CAP_IDLE: if (!en_q) begin   // enable just rose
                  state_o <= CAP_FILL;
                  wr_ptr  <= '0;
                  dbg_cnt <= '0;
               end
               CAP_FILL: if (strobe) begin
                  wr_ptr  <= wr_ptr + 1'b1;
                  dbg_cnt <= dbg_cnt + 1'b1;
                  if (wr_ptr == IDX_W'(`TART_BUF_DEPTH - 1))
                     state_o <= CAP_READY;
               end
               CAP_READY: if (drained_i)
                  state_o <= CAP_DRAINED;
               default: ;   // drained until enable drops
            endcase
         end
      end
   end

   // block buffer, registered read
   always_ff @(posedge fpga_clk) begin
      if (state_o == CAP_FILL && strobe)
         mem[wr_ptr] <= debug_mode_i ? dbg_cnt : ant_q;
      sample_o <= mem[rd_index_i];
   end

endmodule

`default_nettype wire

/* logic/tart_acquire.sv */
`timescale 1ns/1ps
`include "tart_cfg.svh"
`default_nettype none

module tart_acquire (
   input  wire                                 fpga_clk,
   input  wire                                 soft_rst_i,
   input  wire                                 stb_i,
   input  wire tart_pkg::bus_req_t             bus_i,
   output tart_pkg::bus_rsp_t                  rsp_o,
   output logic [2:0]                          sample_delay_o,
   output logic                                debug_mode_o,
   output logic                                aq_enable_o,
   output logic [$clog2(`TART_BUF_DEPTH)-1:0]  rd_index_o,
   input  wire tart_pkg::ant_t                 sample_i,
   input  wire tart_pkg::cap_state_t           state_i,
   output logic                                drained_o
);

   import tart_pkg::*;

   localparam int IDX_W = $clog2(`TART_BUF_DEPTH);

   logic       ack;
   logic       rd_req, wr_req;
   logic       ready;
   logic       streaming;
   logic [1:0] byte_sel;      // 0 = low byte
   logic [7:0] sample_byte;
   logic [7:0] rd_dat;

   assign wr_req    = stb_i & ~ack & bus_i.we;
   assign rd_req    = stb_i & ~ack & ~bus_i.we;
   assign ready     = state_i == CAP_READY;
   assign streaming = rd_req & ready & (bus_i.adr.aq.rsel == 3'd0);

   always_ff @(posedge fpga_clk) begin
      if (soft_rst_i)
         ack <= 1'b0;
      else
         ack <= stb_i & ~ack;   // one cycle after stb
   end

   //--------------------------------------------------
   // control registers
   always_ff @(posedge fpga_clk) begin
      if (soft_rst_i) begin
         sample_delay_o <= '0;
         debug_mode_o   <= 1'b0;
         aq_enable_o    <= 1'b0;
      end else if (wr_req) begin
         case (bus_i.adr.aq.rsel)
            3'd5:    sample_delay_o <= bus_i.dat[2:0];
            3'd6:    debug_mode_o   <= bus_i.dat[0];
            3'd7:    aq_enable_o    <= bus_i.dat[0];
            default: ;
         endcase
      end
   end

   //--------------------------------------------------
   // sample read-back, 3 bytes per sample
   always_ff @(posedge fpga_clk) begin
      if (soft_rst_i || state_i == CAP_IDLE || state_i == CAP_FILL) begin
         byte_sel   <= '0;
         rd_index_o <= '0;
         drained_o  <= 1'b0;
      end else if (streaming) begin
         if (byte_sel == 2'd2) begin
            byte_sel   <= '0;
            rd_index_o <= rd_index_o + 1'b1;   // buffer answers next cycle
            if (rd_index_o == IDX_W'(`TART_BUF_DEPTH - 1))
               drained_o <= 1'b1;
         end else begin
            byte_sel <= byte_sel + 2'd1;
         end
      end
   end

   always_comb begin
      case (byte_sel)
         2'd0:    sample_byte = sample_i[7:0];
         2'd1:    sample_byte = sample_i[15:8];
         default: sample_byte = sample_i[23:16];
      endcase
   end

   always_ff @(posedge fpga_clk) begin
      if (rd_req) begin
         case (bus_i.adr.aq.rsel)
            3'd0:    rd_dat <= ready ? sample_byte : '0;
            3'd5:    rd_dat <= {5'd0, sample_delay_o};
            3'd6:    rd_dat <= {7'd0, debug_mode_o};
            3'd7:    rd_dat <= {7'd0, aq_enable_o};
            default: rd_dat <= '0;
         endcase
      end
   end

   assign rsp_o = '{ack: ack, dat: rd_dat};

endmodule

`default_nettype wire

/* logic/tart_control.sv */
`timescale 1ns/1ps
`include "tart_cfg.svh"
`default_nettype none

module tart_control (
   input  wire                      fpga_clk,
   input  wire                      rst_i,
   input  wire                      stb_i,
   input  wire tart_pkg::bus_req_t  bus_i,
   output tart_pkg::bus_rsp_t       rsp_o,
   input  wire [7:0]                status_i,
   output wire                      soft_rst_o
);

   localparam int CNT_W = $clog2(`TART_RESET_TIME + 1);

   logic             ack;
   logic             req;
   logic             reg0;
   logic [7:0]       rd_dat;
   logic [CNT_W-1:0] rst_cnt;

   assign req  = stb_i & ~ack;   // first cycle of the strobe
   assign reg0 = bus_i.adr.ctrl.rsel == 2'd0;

   always_ff @(posedge fpga_clk) begin
      if (rst_i)
         ack <= 1'b0;
      else
         ack <= req;
   end

   always_ff @(posedge fpga_clk) begin
      if (req)
         rd_dat <= reg0 ? status_i : '0;   // regs 1..3 read zero
   end

   //--------------------------------------------------
   // soft reset pulse
   always_ff @(posedge fpga_clk) begin
      if (rst_i)
         rst_cnt <= '0;
      else if (req && bus_i.we && reg0)
         rst_cnt <= CNT_W'(`TART_RESET_TIME);
      else if (rst_cnt != '0)
         rst_cnt <= rst_cnt - 1'b1;
   end

   assign soft_rst_o = rst_i | (rst_cnt != '0);   // also follows hard reset
   assign rsp_o      = '{ack: ack, dat: rd_dat};

endmodule

`default_nettype wire

/* logic/bus_decoder.sv */
`timescale 1ns/1ps
`include "tart_cfg.svh"
`default_nettype none

module bus_decoder (
   input  wire                      fpga_clk,
   input  wire                      rst_i,
   input  wire tart_pkg::bus_req_t  bus_i,
   output wire                      aq_stb_o,
   output wire                      ctrl_stb_o,
   input  wire tart_pkg::bus_rsp_t  aq_rsp_i,
   input  wire tart_pkg::bus_rsp_t  ctrl_rsp_i,
   output tart_pkg::bus_rsp_t       bus_o
);

   logic aq_hit, ctrl_hit;
   logic aq_sel, ctrl_sel;
   logic miss_ack;   // unmapped address

   assign aq_hit     = bus_i.adr.aq.unit == `TART_AQ_UNIT;
   assign ctrl_hit   = bus_i.adr.ctrl.unit == `TART_CTRL_UNIT;
   assign aq_stb_o   = bus_i.stb & aq_hit;
   assign ctrl_stb_o = bus_i.stb & ctrl_hit;

   // hold selection until the unit acks
   always_ff @(posedge fpga_clk) begin
      if (rst_i || !bus_i.cyc) begin
         aq_sel   <= 1'b0;
         ctrl_sel <= 1'b0;
         miss_ack <= 1'b0;
      end else begin
         aq_sel   <= aq_rsp_i.ack ? 1'b0 : (aq_sel | aq_stb_o);
         ctrl_sel <= ctrl_rsp_i.ack ? 1'b0 : (ctrl_sel | ctrl_stb_o);
         miss_ack <= bus_i.stb & ~aq_hit & ~ctrl_hit & ~miss_ack;
      end
   end

   assign bus_o.ack = aq_rsp_i.ack | ctrl_rsp_i.ack | miss_ack;
   assign bus_o.dat = ctrl_sel ? ctrl_rsp_i.dat :
                      aq_sel   ? aq_rsp_i.dat   : '0;   // miss reads 0

endmodule

`default_nettype wire

/* logic/spi_wb_master.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_wb_master (
   input  wire                      fpga_clk,
   input  wire                      rst_i,
   input  wire                      sck_i,
   input  wire                      ssel_i,     // active low
   input  wire                      mosi_i,
   output wire                      miso_o,
   input  wire [7:0]                status_i,
   output tart_pkg::bus_req_t       bus_o,
   input  wire tart_pkg::bus_rsp_t  bus_i
);

   logic [2:0] sck_q;
   logic [2:0] ssel_q;
   logic [1:0] mosi_q;
   logic [2:0] bit_cnt;
   logic [7:0] rx_sr;
   logic [7:0] tx_sr;
   logic [7:0] tx_buf;       // next byte to shift out
   logic [7:0] rx_byte;
   logic       cmd_phase;    // first byte of the frame
   logic       sck_rise, sck_fall, ssel_fall, active, byte_done;
   logic       cyc_q, stb_q, we_q;
   logic [6:0] adr_q;
   logic [7:0] dat_q;

   //--------------------------------------------------
   // pin synchronisers, third stage for edges
   always_ff @(posedge fpga_clk) begin
      if (rst_i) begin
         sck_q  <= '0;
         ssel_q <= '1;
      end else begin
         sck_q  <= {sck_q[1:0], sck_i};
         ssel_q <= {ssel_q[1:0], ssel_i};
      end
      mosi_q <= {mosi_q[0], mosi_i};   // same delay as sck
   end

   assign sck_rise  = sck_q[1] & ~sck_q[2];
   assign sck_fall  = ~sck_q[1] & sck_q[2];
   assign ssel_fall = ~ssel_q[1] & ssel_q[2];
   assign active    = ~ssel_q[1];
   assign rx_byte   = {rx_sr[6:0], mosi_q[1]};   // msb first
   assign byte_done = active & sck_rise & (bit_cnt == 3'd7);

   //--------------------------------------------------
   // shift registers
   always_ff @(posedge fpga_clk) begin
      if (rst_i) begin
         bit_cnt   <= '0;
         cmd_phase <= 1'b0;
         tx_sr     <= '0;
      end else if (ssel_fall) begin
         bit_cnt   <= '0;
         cmd_phase <= 1'b1;
         tx_sr     <= status_i;   // status rides out with the command
      end else if (!active) begin
         tx_sr     <= '0;         // miso idles low
      end else begin
         if (sck_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7)
               cmd_phase <= 1'b0;
         end
         if (sck_fall)   // byte boundary loads, else shift
            tx_sr <= (bit_cnt == 3'd0) ? tx_buf : {tx_sr[6:0], 1'b0};
      end
      if (sck_rise)
         rx_sr <= rx_byte;
   end

   assign miso_o = tx_sr[7];

   //--------------------------------------------------
   // bus transfers, one per byte
   always_ff @(posedge fpga_clk) begin
      if (rst_i || !active) begin
         cyc_q <= 1'b0;
         stb_q <= 1'b0;
         we_q  <= 1'b0;
      end else begin
         cyc_q <= 1'b1;
         if (bus_i.ack)
            stb_q <= 1'b0;   // drops the cycle after ack
         if (byte_done) begin
            if (cmd_phase) begin
               we_q  <= rx_byte[7];
               stb_q <= ~rx_byte[7];   // first read right after command
            end else begin
               stb_q <= 1'b1;          // write this byte, or prefetch next
            end
         end
      end
   end

   always_ff @(posedge fpga_clk) begin
      if (byte_done) begin
         if (cmd_phase)
            adr_q <= rx_byte[6:0];   // kept for the whole frame
         else
            dat_q <= rx_byte;
      end
      if (bus_i.ack && !we_q)
         tx_buf <= bus_i.dat;        // goes out during next byte
   end

   assign bus_o = '{cyc: cyc_q, stb: stb_q, we: we_q, adr: adr_q, dat: dat_q};

endmodule

`default_nettype wire

/* logic/tart_pkg.sv */
`include "tart_cfg.svh"
`default_nettype none

package tart_pkg;

   // master side of the byte bus
   typedef struct packed {
      logic [3:0] unit;
      logic [2:0] rsel;
   } aq_adr_t;

   typedef struct packed {
      logic [4:0] unit;
      logic [1:0] rsel;
   } ctrl_adr_t;

   // same 7-bit address, seen by acquire or control
   typedef union packed {
      aq_adr_t   aq;
      ctrl_adr_t ctrl;
   } bus_adr_u;

   typedef struct packed {
      logic                       cyc;
      logic                       stb;   // held until ack
      logic                       we;
      bus_adr_u                   adr;
      logic [`TART_BUS_WIDTH-1:0] dat;
   } bus_req_t;

   typedef struct packed {
      logic                       ack;
      logic [`TART_BUS_WIDTH-1:0] dat;   // valid with ack
   } bus_rsp_t;

   typedef enum logic [2:0] {
      CAP_IDLE    = 3'd0,
      CAP_FILL    = 3'd1,
      CAP_READY   = 3'd2,
      CAP_DRAINED = 3'd3
   } cap_state_t;

   typedef logic [`TART_ANT_WIDTH-1:0] ant_t;

endpackage

`default_nettype wire

/* logic/tart_cfg.svh */
`default_nettype none

`ifndef TART_CFG_SVH
`define TART_CFG_SVH

//--------------------------------------------------
// bus geometry
`define TART_BUS_WIDTH   8
`define TART_ADR_WIDTH   7
`define TART_AQ_UNIT     4'h0     // adr[6:3]
`define TART_CTRL_UNIT   5'h03    // adr[6:2]

//--------------------------------------------------
// capture and reset
`define TART_BUF_DEPTH   16       // samples per capture
`define TART_SAMPLE_DIV  6        // fpga_clk cycles per sample
`define TART_RESET_TIME  4        // soft reset length
`define TART_ANT_WIDTH   24

`endif

`default_nettype wire
